/* branch_target_buffer.sv */
// Direct-mapped branch target buffer with registered lookup and update port
`timescale 1ns/1ps

module branch_target_buffer import fetch_pkg::*; #(
	parameter int BTB_DEPTH = 8
) (
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        reset_sync,
	input  logic        search,
	input  addr_t       search_addr,
	input  logic        hold,
	output logic        result_valid,
	output logic        result_taken,
	output addr_t       result_target,
	input  btb_update_s update
);

	localparam int IDX_W = $clog2(BTB_DEPTH);
	localparam int TAG_W = 30 - IDX_W;

	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [TAG_W-1:0] tag_t;

	logic [BTB_DEPTH-1:0] entry_valid;
	logic [BTB_DEPTH-1:0] entry_taken;
	tag_t  entry_tag    [BTB_DEPTH];
	addr_t entry_target [BTB_DEPTH];

	idx_t s_idx, u_idx;
	logic hit;

	// Word address split into tag and index
	function automatic idx_t idx_of(input addr_t a);
		return a[IDX_W+1:2];
	endfunction

	function automatic tag_t tag_of(input addr_t a);
		return a[31:IDX_W+2];
	endfunction

	assign s_idx = idx_of(search_addr);
	assign u_idx = idx_of(update.inst_addr);
	assign hit = entry_valid[s_idx] && (entry_tag[s_idx] == tag_of(search_addr));

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			entry_valid <= '0;
		end else if (reset_sync) begin
			entry_valid <= '0;
		end else if (update.strobe) begin
			entry_valid[u_idx] <= 1'b1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (update.strobe) begin
			entry_taken[u_idx] <= update.taken;
			entry_tag[u_idx] <= tag_of(update.inst_addr);
			entry_target[u_idx] <= update.target;
		end
	end

	// Lookup result frozen while decode is locked
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			result_valid <= 1'b0;
			result_taken <= 1'b0;
		end else if (reset_sync) begin
			result_valid <= 1'b0;
			result_taken <= 1'b0;
		end else if (!hold) begin
			result_valid <= search;
			result_taken <= search && hit && entry_taken[s_idx];
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!hold)
			result_target <= entry_target[s_idx];
	end

endmodule

/* fetch_addr_queue.sv */
// Show-ahead synchronous FIFO of issued fetch addresses and mode flags
`timescale 1ns/1ps

module fetch_addr_queue #(
	parameter int WIDTH = 33,
	parameter int DEPTH = 8
) (
	input  logic             iCLOCK,
	input  logic             inRESET,
	input  logic             clear,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             full
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW:0] wr_ptr, rd_ptr;    // Extra bit tells full from empty
	logic empty;
	logic do_wr, do_rd;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// Head entry visible without a read
	assign rd_data = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (do_wr && !clear)
			mem[wr_ptr[AW-1:0]] <= wr_data;
	end

endmodule

/* fetch_checker.sv */
// Bound assertions on fetch request, output clear and flush pulse behavior
`timescale 1ns/1ps

module fetch_checker import fetch_pkg::*; (
	input logic       iCLOCK,
	input logic       inRESET,
	input logic       mem_req,
	input logic       mem_busy,
	input logic       clear,
	input logic       predict_flush,
	input fetch_out_s out
);

	int fail_count = 0;

	// Memory takes nothing while busy
	req_not_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_req |-> !mem_busy)
	else begin
		$error("mem_req high while mem_busy is high");
		fail_count++;
	end

	out_cleared: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		clear |=> !out.valid)    // Flush is one kind of clear
	else begin
		$error("out.valid high in the cycle after a clear");
		fail_count++;
	end

	flush_pulse: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		predict_flush |=> !predict_flush)
	else begin
		$error("predict_flush longer than one cycle");
		fail_count++;
	end

endmodule

bind fetch_top fetch_checker chk0 (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.mem_req(mem_req),
	.mem_busy(mem_busy),
	.clear(clear),
	.predict_flush(predict_flush),
	.out(out)
);

/* fetch_ctrl.sv */
// Fetch control with run/idle FSM, fetch PC, issue strobe, clear and flush pulses
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; (
	input  logic  iCLOCK,
	input  logic  inRESET,
	input  logic  reset_sync,
	input  logic  event_start,
	input  logic  event_end,
	input  logic  event_hold,
	input  logic  pcr_set,
	input  addr_t pcr,
	input  logic  fetch_stop,
	input  logic  next_lock,
	input  logic  mem_busy,
	input  logic  queue_full,
	input  logic  filter_full,
	input  logic  btb_valid,
	input  logic  btb_taken,
	input  addr_t btb_target,
	output logic  mem_req,
	output addr_t fetch_addr,
	output logic  clear,
	output logic  flush,
	output addr_t flush_addr
);

	fetch_state_e state, state_n;
	addr_t pc, pc_n;
	logic redirect;

	assign redirect = event_end && pcr_set;

	// Taken prediction at the output when decode takes it
	assign flush = btb_valid && btb_taken && !next_lock && !event_hold;
	assign flush_addr = btb_target;

	// Redirect also drops everything in flight
	assign clear = reset_sync || redirect || event_start || flush;

	assign mem_req = (state == FETCH_READ) && !clear && !flush && !event_hold &&
		!queue_full && !filter_full && !mem_busy && !fetch_stop;

	assign fetch_addr = pc;

	always_comb begin
		state_n = state;
		pc_n = pc;
		if (reset_sync) begin
			state_n = FETCH_IDLE;
			pc_n = '0;
		end else if (redirect) begin
			state_n = FETCH_READ;             // Resume at once
			pc_n = {pcr[31:2], 2'b00};
		end else if (event_start) begin
			state_n = FETCH_IDLE;
			pc_n = '0;
		end else if (event_hold) begin
			state_n = FETCH_IDLE;             // PC kept for the restart
		end else if (flush) begin
			state_n = FETCH_IDLE;
			pc_n = flush_addr;
		end else begin
			if (state == FETCH_IDLE)
				state_n = FETCH_READ;
			if (mem_req)
				pc_n = pc + 32'd4;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= FETCH_IDLE;
			pc <= '0;
		end else begin
			state <= state_n;
			pc <= pc_n;
		end
	end

endmodule

/* fetch_out_reg.sv */
// Output register toward decode with instruction, PC, mode flag and prediction
`timescale 1ns/1ps

module fetch_out_reg import fetch_pkg::*; (
	input  logic       iCLOCK,
	input  logic       inRESET,
	input  logic       clear,
	input  logic       next_lock,
	input  logic       accept,
	input  inst_t      rsp_inst,
	input  addr_t      q_addr,
	input  logic       q_kernel,
	input  logic       btb_taken,
	input  addr_t      btb_target,
	output fetch_out_s out
);

	logic  valid_q;
	logic  kernel_q;
	inst_t inst_q;
	addr_t pc_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET)
			valid_q <= 1'b0;
		else if (clear)
			valid_q <= 1'b0;        // Wrong-path or stale response
		else if (!next_lock)
			valid_q <= accept;
	end

	always_ff @(posedge iCLOCK) begin
		if (!next_lock) begin
			inst_q <= rsp_inst;
			pc_q <= q_addr + 32'd4;
			kernel_q <= q_kernel;
		end
	end

	// BTB result is registered in step with this stage
	always_comb begin
		out.valid = valid_q;
		out.kernel = kernel_q;
		out.inst = inst_q;
		out.pc = pc_q;
		out.predict = valid_q && btb_taken;
		out.predict_addr = btb_target;
	end

endmodule

/* fetch_pkg.sv */
// Fetch stage package with widths, branch opcodes, state enum and result structs
package fetch_pkg;

	typedef logic [31:0] addr_t;     // Byte address
	typedef logic [31:0] inst_t;     // Instruction word
	typedef logic [9:0]  opcode_t;   // Instruction bits 30:21

	localparam opcode_t OPC_B   = 10'h0a0;
	localparam opcode_t OPC_BR  = 10'h0a1;
	localparam opcode_t OPC_BUR = 10'h0a2;

	typedef enum logic [0:0] {
		FETCH_IDLE,
		FETCH_READ
	} fetch_state_e;

	// 99-bit result toward decode
	typedef struct packed {
		logic  valid;
		logic  kernel;
		inst_t inst;
		addr_t pc;           // Fetched address plus 4
		logic  predict;
		addr_t predict_addr;
	} fetch_out_s;

	// Resolved branch from execute
	typedef struct packed {
		logic  strobe;
		logic  taken;
		addr_t target;
		addr_t inst_addr;
	} btb_update_s;

	typedef struct packed {
		logic  valid;
		inst_t inst;
	} mem_rsp_s;

	function automatic logic is_branch(input inst_t inst);
		opcode_t opc;
		opc = inst[30:21];
		return (opc == OPC_B) || (opc == OPC_BR) || (opc == OPC_BUR);
	endfunction

endpackage

/* fetch_response_filter.sv */
// Outstanding and discard counters pairing memory responses with live requests
`timescale 1ns/1ps

module fetch_response_filter #(
	parameter int FILTER_DEPTH = 8
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic clear,
	input  logic issue,
	input  logic rsp_valid,
	output logic accept,
	output logic full
);

	localparam int CNT_W = $clog2(FILTER_DEPTH + 1);
	typedef logic [CNT_W-1:0] cnt_t;

	cnt_t out_cnt;     // Live requests
	cnt_t disc_cnt;    // Requests cut off by a clear
	logic discarding;

	assign discarding = (disc_cnt != '0);
	assign accept = rsp_valid && !discarding && !clear;
	assign full = (out_cnt + disc_cnt) >= cnt_t'(FILTER_DEPTH);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			out_cnt <= '0;
			disc_cnt <= '0;
		end else if (clear) begin
			out_cnt <= '0;
			disc_cnt <= disc_cnt + out_cnt - cnt_t'(rsp_valid);   // All in flight become stale
		end else begin
			out_cnt <= out_cnt + cnt_t'(issue) - cnt_t'(accept);
			disc_cnt <= disc_cnt - cnt_t'(rsp_valid && discarding);
		end
	end

endmodule

/* fetch_top.sv */
// Fetch stage top joining control, address queue, response filter, BTB and output register
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
	parameter int QUEUE_DEPTH = 8,
	parameter int FILTER_DEPTH = 8,
	parameter int BTB_DEPTH = 8
) (
	input  logic        iCLOCK,
	input  logic        inRESET,
	// Memory
	output logic        mem_req,
	output addr_t       mem_addr,
	input  logic        mem_busy,
	input  mem_rsp_s    mem_rsp,
	// Decode
	output fetch_out_s  out,
	input  logic        next_lock,
	input  logic        fetch_stop,
	// Pipeline control
	input  logic        reset_sync,
	input  logic        event_start,
	input  logic        event_end,
	input  logic        event_hold,
	input  logic        pcr_set,
	input  addr_t       pcr,
	input  btb_update_s btb_update,
	input  logic        kernel_mode,
	output logic        predict_flush
);

	localparam int QW = $bits(addr_t) + 1;   // Kernel flag on top

	logic clear, queue_full, filter_full, accept;
	logic btb_valid, btb_taken;
	addr_t btb_target, flush_addr;
	logic [QW-1:0] q_data;

	fetch_ctrl ctrl0 (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.reset_sync(reset_sync), .event_start(event_start), .event_end(event_end),
		.event_hold(event_hold), .pcr_set(pcr_set), .pcr(pcr),
		.fetch_stop(fetch_stop), .next_lock(next_lock), .mem_busy(mem_busy),
		.queue_full(queue_full), .filter_full(filter_full),
		.btb_valid(btb_valid), .btb_taken(btb_taken), .btb_target(btb_target),
		.mem_req(mem_req), .fetch_addr(mem_addr), .clear(clear),
		.flush(predict_flush), .flush_addr(flush_addr)
	);

	fetch_addr_queue #(.WIDTH(QW), .DEPTH(QUEUE_DEPTH)) queue0 (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .clear(clear),
		.wr_en(mem_req), .wr_data({kernel_mode, mem_addr}),
		.rd_en(accept && !next_lock), .rd_data(q_data), .full(queue_full)
	);

	fetch_response_filter #(.FILTER_DEPTH(FILTER_DEPTH)) filter0 (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .clear(clear), .issue(mem_req),
		.rsp_valid(mem_rsp.valid), .accept(accept), .full(filter_full)
	);

	// Lookup only for accepted branches; a clear overrides the lock hold
	branch_target_buffer #(.BTB_DEPTH(BTB_DEPTH)) btb0 (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .reset_sync(reset_sync),
		.search(accept && is_branch(mem_rsp.inst)), .search_addr(q_data[QW-2:0]),
		.hold(next_lock && !clear), .result_valid(btb_valid),
		.result_taken(btb_taken), .result_target(btb_target), .update(btb_update)
	);

	fetch_out_reg outreg0 (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .clear(clear), .next_lock(next_lock),
		.accept(accept), .rsp_inst(mem_rsp.inst), .q_addr(q_data[QW-2:0]),
		.q_kernel(q_data[QW-1]), .btb_taken(btb_taken), .btb_target(flush_addr),
		.out(out)
	);

endmodule

/* list.f */
fetch_pkg.sv
fetch_ctrl.sv
fetch_addr_queue.sv
fetch_response_filter.sv
branch_target_buffer.sv
fetch_out_reg.sv
fetch_top.sv
fetch_checker.sv
tb_fetch.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_fetch \
	-f list.f --Mdir obj_dir -o sim_fetch
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_fetch +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

/* tb_fetch.sv */
// Testbench for the fetch stage with clock, memory model, directed tests and summary
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*; ();

	localparam addr_t BR_ADDR   = 32'h0000_0318;   // Only branch in memory
	localparam addr_t BR_TARGET = 32'h0000_0400;

	logic        iCLOCK;
	logic        inRESET;
	logic        mem_req;
	addr_t       mem_addr;
	logic        mem_busy = 1'b0;
	mem_rsp_s    mem_rsp = '0;
	fetch_out_s  out;
	logic        next_lock = 1'b0;
	logic        fetch_stop;
	logic        reset_sync;
	logic        event_start;
	logic        event_end;
	logic        event_hold;
	logic        pcr_set;
	addr_t       pcr;
	btb_update_s btb_update;
	logic        kernel_mode;
	logic        predict_flush;

	fetch_out_s got[$];          // Everything decode took
	addr_t pend_addr[$];         // Requests the memory still owes
	int pend_cycle[$];
	int base_idx = 0;
	int cycle = 0;
	int flushes = 0;
	int held_reqs = 0;
	bit rand_mode = 1'b0;
	logic [31:0] rng = 32'd70;
	string cur_test;
	int errors = 0;
	int err_start;
	int n_tests = 0;
	int n_failed = 0;

	fetch_top #(.QUEUE_DEPTH(8), .FILTER_DEPTH(8), .BTB_DEPTH(8)) dut0 (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #4 iCLOCK = ~iCLOCK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Memory contents
	function automatic inst_t mem_word(input addr_t a);
		if (a == BR_ADDR)
			return {1'b0, OPC_B, a[20:0]};
		return a ^ 32'h5A5A_0000;
	endfunction

	function automatic fetch_out_s make_out(input addr_t a, input logic k);
		fetch_out_s o;
		o = '0;
		o.valid = 1'b1;
		o.kernel = k;
		o.inst = mem_word(a);
		o.pc = a + 32'd4;
		return o;
	endfunction

	function automatic fetch_out_s got_at(input int i);
		if (base_idx + i < got.size())
			return got[base_idx + i];
		return '0;
	endfunction

	// Issue tracking and decode side sampled on the rising edge
	always @(posedge iCLOCK) begin
		if (inRESET) begin
			cycle++;
			if (mem_req) begin
				pend_addr.push_back(mem_addr);
				pend_cycle.push_back(cycle);
			end
			if (mem_req && (event_hold || fetch_stop))
				held_reqs++;
			if (predict_flush)
				flushes++;
			if (out.valid && !next_lock && !event_start && !(event_end && pcr_set))
				got.push_back(out);
		end
	end

	// In-order responses after 2 to 4 cycles and never while decode is locked
	always @(negedge iCLOCK) begin : drive_memory
		logic lock_n;
		mem_rsp_s rsp;
		int lat;
		rng = xorshift(rng);
		lock_n = rand_mode && rng[0] && rng[1];
		lat = 2 + int'(rng[5:4] % 2'd3);
		rsp = '0;
		if (!lock_n && pend_addr.size() > 0 && cycle - pend_cycle[0] >= lat) begin
			rsp.valid = 1'b1;
			rsp.inst = mem_word(pend_addr.pop_front());
			void'(pend_cycle.pop_front());
		end
		next_lock <= lock_n;
		mem_busy <= rand_mode && rng[2];
		mem_rsp <= rsp;
	end

	task automatic check_out(input string what, input fetch_out_s exp, input fetch_out_s act);
		fetch_out_s a;
		a = act;
		if (!exp.predict)
			a.predict_addr = exp.predict_addr;    // No target without a prediction
		if (a !== exp) begin
			$display("Error %s %s: expected %h actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_addr(input string what, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			$display("Error %s %s: expected %h actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (act != exp) begin
			$display("Error %s %s: expected %0d actual %0d", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_stream(input int first, input addr_t base, input int n, input logic k);
		for (int i = 0; i < n; i++)
			check_out($sformatf("item %0d", first + i), make_out(base + 32'(4 * i), k),
				got_at(first + i));
	endtask

	task automatic wait_outputs(input int n);
		int t;
		t = 0;
		while (got.size() - base_idx < n && t < 1000) begin
			@(negedge iCLOCK);
			t++;
		end
		if (got.size() - base_idx < n) begin
			$display("%s: timed out waiting for %0d outputs, only %0d arrived",
				cur_test, n, got.size() - base_idx);
			errors++;
		end
	endtask

	task automatic restart(input addr_t a, input logic k);
		@(negedge iCLOCK);
		event_end = 1'b1;
		pcr_set = 1'b1;
		pcr = a;
		kernel_mode = k;
		base_idx = got.size();
		@(negedge iCLOCK);
		event_end = 1'b0;
		pcr_set = 1'b0;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_start = errors;
		n_tests++;
	endtask

	task automatic finish_test();
		if (errors == err_start) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: failed with %0d errors", cur_test, errors - err_start);
			n_failed++;
		end
	endtask

	task automatic sequential_fetch();
		start_test("sequential");
		wait_outputs(16);
		check_stream(0, 32'h0, 16, 1'b1);
		finish_test();
	endtask

	task automatic pcr_redirect();
		start_test("redirect");
		restart(32'h0000_0101, 1'b0);     // Low bits dropped by fetch
		wait_outputs(12);
		check_stream(0, 32'h0000_0100, 12, 1'b0);
		finish_test();
	endtask

	task automatic random_backpressure();
		start_test("backpressure");
		restart(32'h0000_0200, 1'b0);
		@(posedge iCLOCK);
		rand_mode = 1'b1;
		wait_outputs(40);
		@(posedge iCLOCK);
		rand_mode = 1'b0;
		check_stream(0, 32'h0000_0200, 40, 1'b0);
		finish_test();
	endtask

	task automatic branch_prediction();
		fetch_out_s exp;
		fetch_out_s act;
		int f0;
		start_test("predict");
		@(negedge iCLOCK);
		btb_update.strobe = 1'b1;
		btb_update.taken = 1'b1;
		btb_update.target = BR_TARGET;
		btb_update.inst_addr = BR_ADDR;
		@(negedge iCLOCK);
		btb_update = '0;
		f0 = flushes;
		restart(32'h0000_0300, 1'b0);
		wait_outputs(11);
		check_stream(0, 32'h0000_0300, 6, 1'b0);
		exp = make_out(BR_ADDR, 1'b0);
		exp.predict = 1'b1;
		exp.predict_addr = BR_TARGET;
		act = got_at(6);
		check_out("branch", exp, act);
		check_addr("predict_addr", BR_TARGET, act.predict_addr);
		check_count("flush pulses", 1, flushes - f0);
		check_stream(7, BR_TARGET, 4, 1'b0);    // Stream resumes at the target
		finish_test();
	endtask

	task automatic hold_and_stop();
		int h0;
		start_test("hold_stop");
		restart(32'h0000_0500, 1'b1);
		wait_outputs(4);
		h0 = held_reqs;
		@(negedge iCLOCK);
		event_hold = 1'b1;
		repeat (10) @(negedge iCLOCK);
		event_hold = 1'b0;
		repeat (3) @(negedge iCLOCK);
		fetch_stop = 1'b1;
		repeat (10) @(negedge iCLOCK);
		fetch_stop = 1'b0;
		wait_outputs(20);
		check_count("requests while held", 0, held_reqs - h0);
		check_stream(0, 32'h0000_0500, 20, 1'b1);
		finish_test();
	endtask

	task automatic event_start_restart();
		start_test("event_start");
		restart(32'h0000_0600, 1'b0);
		wait_outputs(3);
		@(negedge iCLOCK);
		event_start = 1'b1;
		base_idx = got.size();
		@(negedge iCLOCK);
		event_start = 1'b0;
		wait_outputs(8);
		check_stream(0, 32'h0, 8, 1'b0);
		finish_test();
	endtask

	initial begin
		int assert_fails;
		inRESET = 1'b0;
		fetch_stop = 1'b0;
		reset_sync = 1'b0;
		event_start = 1'b0;
		event_end = 1'b0;
		event_hold = 1'b0;
		pcr_set = 1'b0;
		pcr = '0;
		btb_update = '0;
		kernel_mode = 1'b1;
		repeat (2) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		sequential_fetch();
		pcr_redirect();
		random_backpressure();
		branch_prediction();
		hold_and_stop();
		event_start_restart();
		assert_fails = dut0.chk0.fail_count;
		$display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
			n_tests, n_failed, errors, assert_fails);
		if (errors == 0 && assert_fails == 0 && n_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
